// File: design/boot_rom.hex
00000013
00100093
00200113
00300193
00400213
00500293
00600313
00700393
00800413
00900493
00a00513
00b00593
00c00613
00d00693
00e00713
00f00793

// File: dv/soc_bus_stim.txt
# op addr wdata wstrb expect fetch_expect (all hex)
# P: wdata is the poll mask. B: wdata is the fetch address, wstrb 1 if the fetch is dropped
I 00000000 00000000 0 00000013 00000000
I 00000004 00000000 0 00100093 00000000
D 00000008 00000000 0 00200113 00000000
D 0000003c 00000000 0 00f00793 00000000
W 02000000 00000001 f 00000000 00000000
Q 00000000 00000000 0 00000001 00000000
D 02000000 00000000 0 00000001 00000000
W 02000000 00000000 f 00000000 00000000
Q 00000000 00000000 0 00000000 00000000
T 0200bff8 00000000 0 00001000 00000000
N 00000014 00000000 0 00000000 00000000
T 0200bff8 00000000 0 00000040 00000000
W 02004004 00000000 f 00000000 00000000
A 02004000 00000032 f 00000000 00000000
Q 00000000 00000000 0 00000000 00000000
N 0000003c 00000000 0 00000000 00000000
Q 00000000 00000000 0 00000002 00000000
W 02004000 ffffffff f 00000000 00000000
W 02004004 ffffffff f 00000000 00000000
Q 00000000 00000000 0 00000000 00000000
W 00100000 000000a5 1 00000000 00000000
D 00100004 00000000 0 00000001 00000000
P 00100004 00000002 0 00000002 00000000
D 00100000 00000000 0 000000a5 00000000
D 00100004 00000000 0 00000000 00000000
B 00000010 00000014 1 00400213 00000000
B 02000000 00000018 0 00000000 00600313

// File: src.f
design/soc_pkg.sv
design/bus_router.sv
design/boot_rom.sv
design/clint_timer.sv
design/uart_port.sv
design/soc_bus.sv
dv/soc_bus_assert.sv
dv/soc_bus_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= soc_bus_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/soc_bus_tb.sv
`timescale 1ns/1ps
`default_nettype none

module soc_bus_tb;
  import soc_pkg::*;

  logic        clock;
  logic        reset;
  mem_req_t    imem_req;
  mem_req_t    dmem_req;
  mem_rsp_t    imem_rsp;
  mem_rsp_t    dmem_rsp;
  wire logic   line;      // tx looped back to rx
  logic        msip;
  logic        mtip;
  logic [63:0] mtime;

  byte         op_q[$];
  logic [31:0] addr_q[$];
  logic [31:0] wdata_q[$];
  logic [31:0] wstrb_q[$];
  logic [31:0] exp_q[$];
  logic [31:0] iexp_q[$];

  soc_bus soc_bus_i (
    .clock      (clock),
    .reset      (reset),
    .imem_req_i (imem_req),
    .dmem_req_i (dmem_req),
    .imem_rsp_o (imem_rsp),
    .dmem_rsp_o (dmem_rsp),
    .rx_i       (line),
    .tx_o       (line),
    .msip_o     (msip),
    .mtip_o     (mtip),
    .mtime_o    (mtime)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  task automatic report_failure(input string msg);
    $display("CHECK FAILED at time %0t: %s", $time, msg);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  function automatic mem_req_t make_req(input logic instr, input logic [31:0] addr,
                                        input logic [31:0] wdata, input logic [3:0] wstrb);
    mem_req_t req;
    req = '{valid: 1'b1, instr: instr, addr: addr, wdata: wdata, wstrb: wstrb};
    return req;
  endfunction

  // Response is sampled mid-cycle, one cycle after the request
  task automatic bus_cycle(input mem_req_t ireq, input mem_req_t dreq,
                           output mem_rsp_t irsp, output mem_rsp_t drsp);
    @(posedge clock);
    imem_req <= ireq;
    dmem_req <= dreq;
    @(posedge clock);
    imem_req <= '0;
    dmem_req <= '0;
    @(negedge clock);
    irsp = imem_rsp;
    drsp = dmem_rsp;
  endtask

  task automatic check_rsp(input mem_rsp_t rsp, input logic exp_ready,
                           input logic [31:0] exp_data, input logic [31:0] mask,
                           input string what);
    if (rsp.ready !== exp_ready) begin
      report_failure($sformatf("%s: ready %b, expected %b", what, rsp.ready, exp_ready));
    end else if (exp_ready && ((rsp.rdata & mask) !== (exp_data & mask))) begin
      report_failure($sformatf("%s: rdata %h, expected %h", what, rsp.rdata, exp_data));
    end
  endtask

  task automatic check_irq(input logic exp_msip, input logic exp_mtip, input string what);
    if (msip !== exp_msip || mtip !== exp_mtip) begin
      report_failure($sformatf("%s: msip %b mtip %b, expected %b %b",
                               what, msip, mtip, exp_msip, exp_mtip));
    end
  endtask

  task automatic check_line(input logic exp_tx, input string what);
    if (line !== exp_tx) begin
      report_failure($sformatf("%s: tx %b, expected %b", what, line, exp_tx));
    end
  endtask

  task automatic check_time(input logic [63:0] now, input logic [63:0] prev,
                            input logic [63:0] window, input string what);
    if (now < prev || now - prev > window) begin
      report_failure($sformatf("%s: %0d after %0d, allowed step %0d",
                               what, now, prev, window));
    end
  endtask

  task automatic load_stim();
    int    fd;
    int    n;
    string text;
    byte         op;
    logic [31:0] a;
    logic [31:0] w;
    logic [31:0] s;
    logic [31:0] e;
    logic [31:0] ie;
    fd = $fopen("dv/soc_bus_stim.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file dv/soc_bus_stim.txt");
      $display("CHECKS FAILED");
      $fatal(1, "no stimulus");
    end
    while (!$feof(fd)) begin
      text = "";
      n = $fgets(text, fd);
      if (text.len() < 2 || text[0] == "#") begin
        continue;
      end
      n = $sscanf(text, "%c %h %h %h %h %h", op, a, w, s, e, ie);
      if (n != 6) begin
        $display("Malformed stimulus line: %s", text);
        $display("CHECKS FAILED");
        $fatal(1, "bad stimulus");
      end
      op_q.push_back(op);
      addr_q.push_back(a);
      wdata_q.push_back(w);
      wstrb_q.push_back(s);
      exp_q.push_back(e);
      iexp_q.push_back(ie);
    end
    $fclose(fd);
  endtask

  initial begin
    mem_rsp_t    irsp;
    mem_rsp_t    drsp;
    logic [31:0] last_rd;
    longint      limit;
    reset    = 1'b0;
    imem_req = '0;
    dmem_req = '0;
    last_rd  = '0;
    load_stim();
    limit = longint'(op_q.size()) * 12 * CLKS_PER_BIT + 200;

    fork
      begin
        repeat (limit) @(posedge clock);
        $display("Timeout: the run exceeded %0d cycles", limit);
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
      end
    join_none

    repeat (8) @(posedge clock);
    reset <= 1'b1;

    // Idle values right after reset
    @(negedge clock);
    check_rsp(imem_rsp, 1'b0, '0, '0, "fetch port after reset");
    check_rsp(dmem_rsp, 1'b0, '0, '0, "data port after reset");
    check_irq(1'b0, 1'b0, "interrupt lines after reset");
    check_line(1'b1, "tx line after reset");
    check_time(mtime, 64'd0, 64'd0, "mtime after reset");

    for (int i = 0; i < op_q.size(); i++) begin
      case (op_q[i])
        "I": begin
          bus_cycle(make_req(1'b1, addr_q[i], '0, '0), '0, irsp, drsp);
          check_rsp(irsp, 1'b1, exp_q[i], '1, "fetch read");
          check_rsp(drsp, 1'b0, '0, '0, "idle data port");
        end
        "D": begin
          bus_cycle('0, make_req(1'b0, addr_q[i], '0, '0), irsp, drsp);
          check_rsp(drsp, 1'b1, exp_q[i], '1, "data read");
          check_rsp(irsp, 1'b0, '0, '0, "idle fetch port");
        end
        "W": begin
          bus_cycle('0, make_req(1'b0, addr_q[i], wdata_q[i], wstrb_q[i][3:0]), irsp, drsp);
          check_rsp(drsp, 1'b1, '0, '0, "data write");
        end
        "A": begin
          bus_cycle('0, make_req(1'b0, addr_q[i], last_rd + wdata_q[i], wstrb_q[i][3:0]),
                    irsp, drsp);
          check_rsp(drsp, 1'b1, '0, '0, "compare write");
        end
        "B": begin
          bus_cycle(make_req(1'b1, wdata_q[i], '0, '0), make_req(1'b0, addr_q[i], '0, '0),
                    irsp, drsp);
          check_rsp(drsp, 1'b1, exp_q[i], '1, "data read beside fetch");
          if (wstrb_q[i][0]) begin
            check_rsp(irsp, 1'b0, '0, '0, "dropped fetch");
            @(negedge clock);
            check_rsp(imem_rsp, 1'b0, '0, '0, "dropped fetch one cycle later");
          end else begin
            check_rsp(irsp, 1'b1, iexp_q[i], '1, "parallel fetch");
          end
        end
        "P": begin
          do begin
            bus_cycle('0, make_req(1'b0, addr_q[i], '0, '0), irsp, drsp);
            check_rsp(drsp, 1'b1, '0, '0, "poll read");
          end while ((drsp.rdata & wdata_q[i]) != exp_q[i]);
        end
        "T": begin
          bus_cycle('0, make_req(1'b0, addr_q[i], '0, '0), irsp, drsp);
          check_rsp(drsp, 1'b1, '0, '0, "mtime read");
          check_time({32'b0, drsp.rdata}, {32'b0, last_rd}, {32'b0, exp_q[i]}, "mtime step");
          check_time(mtime, {32'b0, drsp.rdata}, 64'd4, "mtime port");
          last_rd = drsp.rdata;
        end
        "Q": begin
          @(negedge clock);
          check_irq(exp_q[i][0], exp_q[i][1], "interrupt lines");
        end
        "N": begin
          repeat (addr_q[i]) @(posedge clock);
        end
        default: begin
          report_failure($sformatf("unknown operation %c on entry %0d", op_q[i], i));
        end
      endcase
    end

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/soc_bus_assert.sv
`timescale 1ns/1ps
`default_nettype none

module soc_bus_assert (
  input wire logic              clock,
  input wire logic              reset,
  input wire soc_pkg::mem_req_t rom_req,
  input wire soc_pkg::mem_req_t uart_req,
  input wire soc_pkg::mem_req_t clint_req,
  input wire soc_pkg::mem_rsp_t rom_rsp,
  input wire soc_pkg::mem_rsp_t uart_rsp,
  input wire soc_pkg::mem_rsp_t clint_rsp,
  input wire soc_pkg::mem_rsp_t imem_rsp,
  input wire soc_pkg::mem_rsp_t dmem_rsp,
  input wire logic              mtip
);
  import soc_pkg::*;

  logic timer_wr;

  // Writes to mtimecmp or mtime, either half
  assign timer_wr = clint_req.valid && (clint_req.wstrb != 4'b0000) &&
                    (clint_req.addr == CLINT_MTIMECMP || clint_req.addr == CLINT_MTIMECMPH ||
                     clint_req.addr == CLINT_MTIME || clint_req.addr == CLINT_MTIMEH);

  rom_ready_a: assert property (@(posedge clock) disable iff (!reset)
    rom_req.valid |=> rom_rsp.ready) else $error("ROM missed ready");
  uart_ready_a: assert property (@(posedge clock) disable iff (!reset)
    uart_req.valid |=> uart_rsp.ready) else $error("UART missed ready");
  clint_ready_a: assert property (@(posedge clock) disable iff (!reset)
    clint_req.valid |=> clint_rsp.ready) else $error("CLINT missed ready");

  // Both ports answered needs two different slaves
  split_rsp_a: assert property (@(posedge clock) disable iff (!reset)
    (imem_rsp.ready && dmem_rsp.ready) |->
      ($countones({rom_rsp.ready, uart_rsp.ready, clint_rsp.ready}) >= 2))
    else $error("Both ports answered by one slave");

  mtip_fall_a: assert property (@(posedge clock) disable iff (!reset)
    $fell(mtip) |-> $past(timer_wr)) else $error("mtip fell without a timer write");

endmodule

bind soc_bus soc_bus_assert soc_bus_assert_i (
  .clock     (clock),
  .reset     (reset),
  .rom_req   (rom_req),
  .uart_req  (uart_req),
  .clint_req (clint_req),
  .rom_rsp   (rom_rsp),
  .uart_rsp  (uart_rsp),
  .clint_rsp (clint_rsp),
  .imem_rsp  (imem_rsp_o),
  .dmem_rsp  (dmem_rsp_o),
  .mtip      (mtip_o)
);

`default_nettype wire

// File: design/soc_bus.sv
`timescale 1ns/1ps
`default_nettype none

module soc_bus (
  input  wire logic              clock,
  input  wire logic              reset,
  input  wire soc_pkg::mem_req_t imem_req_i,
  input  wire soc_pkg::mem_req_t dmem_req_i,
  output soc_pkg::mem_rsp_t      imem_rsp_o,
  output soc_pkg::mem_rsp_t      dmem_rsp_o,
  input  wire logic              rx_i,
  output logic                   tx_o,
  output logic                   msip_o,
  output logic                   mtip_o,
  output logic [63:0]            mtime_o
);
  import soc_pkg::*;

  mem_req_t rom_req;
  mem_req_t uart_req;
  mem_req_t clint_req;
  mem_rsp_t rom_rsp;
  mem_rsp_t uart_rsp;
  mem_rsp_t clint_rsp;

  bus_router bus_router_i (
    .clock       (clock),
    .reset       (reset),
    .imem_req_i  (imem_req_i),
    .dmem_req_i  (dmem_req_i),
    .imem_rsp_o  (imem_rsp_o),
    .dmem_rsp_o  (dmem_rsp_o),
    .rom_req_o   (rom_req),
    .uart_req_o  (uart_req),
    .clint_req_o (clint_req),
    .rom_rsp_i   (rom_rsp),
    .uart_rsp_i  (uart_rsp),
    .clint_rsp_i (clint_rsp)
  );

  boot_rom boot_rom_i (
    .clock (clock),
    .reset (reset),
    .req_i (rom_req),
    .rsp_o (rom_rsp)
  );

  clint_timer clint_timer_i (
    .clock   (clock),
    .reset   (reset),
    .req_i   (clint_req),
    .rsp_o   (clint_rsp),
    .msip_o  (msip_o),
    .mtip_o  (mtip_o),
    .mtime_o (mtime_o)
  );

  uart_port uart_port_i (
    .clock (clock),
    .reset (reset),
    .req_i (uart_req),
    .rsp_o (uart_rsp),
    .rx_i  (rx_i),
    .tx_o  (tx_o)
  );

endmodule

`default_nettype wire

// File: design/uart_port.sv
`timescale 1ns/1ps
`default_nettype none

module uart_port (
  input  wire logic              clock,
  input  wire logic              reset,
  input  wire soc_pkg::mem_req_t req_i,
  output soc_pkg::mem_rsp_t      rsp_o,
  input  wire logic              rx_i,
  output logic                   tx_o
);
  import soc_pkg::*;

  uart_state_e           tx_state_q;
  uart_state_e           rx_state_q;
  logic [UART_CNT_W-1:0] tx_cnt_q;
  logic [UART_CNT_W-1:0] rx_cnt_q;
  logic [2:0]            tx_bit_q;
  logic [2:0]            rx_bit_q;
  logic [7:0]            tx_shift_q;
  logic [7:0]            rx_shift_q;
  logic [7:0]            rx_data_q;
  logic                  rx_full_q;
  logic [1:0]            rx_sync_q;
  logic                  rx_line;
  logic                  tx_busy;
  logic                  wr_data;
  logic                  rd_data;
  logic                  ready_q;
  logic [31:0]           rdata_q;
  logic [31:0]           rd_word;

  assign wr_data = req_i.valid && (req_i.addr == UART_DATA) && req_i.wstrb[0];
  assign rd_data = req_i.valid && (req_i.addr == UART_DATA) && (req_i.wstrb == 4'b0000);
  assign tx_busy = (tx_state_q != UART_IDLE);
  assign rx_line = rx_sync_q[1];

  always_comb begin
    case (tx_state_q)
      UART_START: tx_o = 1'b0;
      UART_BITS:  tx_o = tx_shift_q[0];  // LSB first
      default:    tx_o = 1'b1;
    endcase
  end

  // Transmit FSM, a write while busy is dropped
  always_ff @(posedge clock) begin
    if (!reset) begin
      tx_state_q <= UART_IDLE;
      tx_cnt_q   <= '0;
      tx_bit_q   <= '0;
    end else begin
      if (tx_state_q == UART_IDLE || tx_cnt_q == UART_BIT_END) begin
        tx_cnt_q <= '0;
      end else begin
        tx_cnt_q <= tx_cnt_q + 1'b1;
      end
      case (tx_state_q)
        UART_IDLE: begin
          if (wr_data) begin
            tx_state_q <= UART_START;
          end
        end
        UART_START: begin
          if (tx_cnt_q == UART_BIT_END) begin
            tx_state_q <= UART_BITS;
            tx_bit_q   <= '0;
          end
        end
        UART_BITS: begin
          if (tx_cnt_q == UART_BIT_END) begin
            tx_bit_q <= tx_bit_q + 1'b1;
            if (tx_bit_q == 3'd7) begin
              tx_state_q <= UART_STOP;
            end
          end
        end
        default: begin
          if (tx_cnt_q == UART_BIT_END) begin
            tx_state_q <= UART_IDLE;
          end
        end
      endcase
    end
  end

  // Receive FSM, samples at mid-bit
  always_ff @(posedge clock) begin
    if (!reset) begin
      rx_sync_q  <= 2'b11;
      rx_state_q <= UART_IDLE;
      rx_cnt_q   <= '0;
      rx_bit_q   <= '0;
      rx_full_q  <= 1'b0;
    end else begin
      rx_sync_q <= {rx_sync_q[0], rx_i};
      if (rd_data) begin
        rx_full_q <= 1'b0;
      end
      case (rx_state_q)
        UART_IDLE: begin
          rx_cnt_q <= '0;
          if (!rx_line) begin
            rx_state_q <= UART_START;
          end
        end
        UART_START: begin
          if (rx_cnt_q == UART_BIT_MID) begin
            rx_cnt_q   <= '0;
            rx_bit_q   <= '0;
            rx_state_q <= rx_line ? UART_IDLE : UART_BITS;  // False start
          end else begin
            rx_cnt_q <= rx_cnt_q + 1'b1;
          end
        end
        UART_BITS: begin
          if (rx_cnt_q == UART_BIT_END) begin
            rx_cnt_q <= '0;
            rx_bit_q <= rx_bit_q + 1'b1;
            if (rx_bit_q == 3'd7) begin
              rx_state_q <= UART_STOP;
            end
          end else begin
            rx_cnt_q <= rx_cnt_q + 1'b1;
          end
        end
        default: begin
          if (rx_cnt_q == UART_BIT_END) begin
            rx_cnt_q   <= '0;
            rx_state_q <= UART_IDLE;
            if (rx_line) begin
              rx_full_q <= 1'b1;  // Good stop bit
            end
          end else begin
            rx_cnt_q <= rx_cnt_q + 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (tx_state_q == UART_IDLE && wr_data) begin
      tx_shift_q <= req_i.wdata[7:0];
    end else if (tx_state_q == UART_BITS && tx_cnt_q == UART_BIT_END) begin
      tx_shift_q <= {1'b1, tx_shift_q[7:1]};
    end
    if (rx_state_q == UART_BITS && rx_cnt_q == UART_BIT_END) begin
      rx_shift_q <= {rx_line, rx_shift_q[7:1]};
    end
    if (rx_state_q == UART_STOP && rx_cnt_q == UART_BIT_END && rx_line) begin
      rx_data_q <= rx_shift_q;
    end
  end

  always_comb begin
    case (req_i.addr)
      UART_DATA:   rd_word = {24'b0, rx_data_q};
      UART_STATUS: rd_word = {30'b0, rx_full_q, tx_busy};
      default:     rd_word = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= req_i.valid;
    end
  end

  always_ff @(posedge clock) begin
    rdata_q <= req_i.valid ? rd_word : '0;
  end

  assign rsp_o = '{ready: ready_q, rdata: rdata_q};

endmodule

`default_nettype wire

// File: design/clint_timer.sv
`timescale 1ns/1ps
`default_nettype none

module clint_timer (
  input  wire logic              clock,
  input  wire logic              reset,
  input  wire soc_pkg::mem_req_t req_i,
  output soc_pkg::mem_rsp_t      rsp_o,
  output logic                   msip_o,
  output logic                   mtip_o,
  output logic [63:0]            mtime_o
);
  import soc_pkg::*;

  logic [63:0] mtime_q;
  logic [63:0] mtimecmp_q;
  logic        msip_q;
  logic        ready_q;
  logic [31:0] rdata_q;
  logic [31:0] rd_word;
  logic        wr_en;

  function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] wdata,
                                        input logic [3:0] wstrb);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (wstrb[b]) begin
        res[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign wr_en = req_i.valid && (req_i.wstrb != 4'b0000);

  always_comb begin
    case (req_i.addr)
      CLINT_MSIP:      rd_word = {31'b0, msip_q};
      CLINT_MTIMECMP:  rd_word = mtimecmp_q[31:0];
      CLINT_MTIMECMPH: rd_word = mtimecmp_q[63:32];
      CLINT_MTIME:     rd_word = mtime_q[31:0];
      CLINT_MTIMEH:    rd_word = mtime_q[63:32];
      default:         rd_word = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      msip_q     <= 1'b0;
      mtime_q    <= '0;
      mtimecmp_q <= '1;  // No timer interrupt until programmed
      ready_q    <= 1'b0;
    end else begin
      ready_q <= req_i.valid;
      mtime_q <= mtime_q + 64'd1;
      if (wr_en) begin
        case (req_i.addr)
          CLINT_MSIP: begin
            if (req_i.wstrb[0]) begin
              msip_q <= req_i.wdata[0];
            end
          end
          CLINT_MTIMECMP:  mtimecmp_q[31:0]  <= merge(mtimecmp_q[31:0], req_i.wdata, req_i.wstrb);
          CLINT_MTIMECMPH: mtimecmp_q[63:32] <= merge(mtimecmp_q[63:32], req_i.wdata, req_i.wstrb);
          CLINT_MTIME:     mtime_q[31:0]     <= merge(mtime_q[31:0], req_i.wdata, req_i.wstrb);
          CLINT_MTIMEH:    mtime_q[63:32]    <= merge(mtime_q[63:32], req_i.wdata, req_i.wstrb);
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clock) begin
    rdata_q <= req_i.valid ? rd_word : '0;
  end

  assign rsp_o   = '{ready: ready_q, rdata: rdata_q};
  assign msip_o  = msip_q;
  assign mtip_o  = (mtime_q >= mtimecmp_q);
  assign mtime_o = mtime_q;

endmodule

`default_nettype wire

// File: design/boot_rom.sv
`timescale 1ns/1ps
`default_nettype none

module boot_rom (
  input  wire logic              clock,
  input  wire logic              reset,
  input  wire soc_pkg::mem_req_t req_i,
  output soc_pkg::mem_rsp_t      rsp_o
);
  import soc_pkg::*;

  logic [31:0] mem [ROM_WORDS];
  logic        ready_q;
  logic [31:0] rdata_q;

  initial begin
    $readmemh("design/boot_rom.hex", mem);
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= req_i.valid;  // Writes are acknowledged only
    end
  end

  // Word index from the rebased address
  always_ff @(posedge clock) begin
    rdata_q <= req_i.valid ? mem[req_i.addr[5:2]] : '0;
  end

  assign rsp_o = '{ready: ready_q, rdata: rdata_q};

endmodule

`default_nettype wire

// File: design/bus_router.sv
`timescale 1ns/1ps
`default_nettype none

module bus_router (
  input  wire logic              clock,
  input  wire logic              reset,
  input  wire soc_pkg::mem_req_t imem_req_i,
  input  wire soc_pkg::mem_req_t dmem_req_i,
  output soc_pkg::mem_rsp_t      imem_rsp_o,
  output soc_pkg::mem_rsp_t      dmem_rsp_o,
  output soc_pkg::mem_req_t      rom_req_o,
  output soc_pkg::mem_req_t      uart_req_o,
  output soc_pkg::mem_req_t      clint_req_o,
  input  wire soc_pkg::mem_rsp_t rom_rsp_i,
  input  wire soc_pkg::mem_rsp_t uart_rsp_i,
  input  wire soc_pkg::mem_rsp_t clint_rsp_i
);
  import soc_pkg::*;

  slave_e     i_sel;
  slave_e     d_sel;
  mem_req_t   i_fwd;
  mem_req_t   d_fwd;
  logic [2:0] i_hit;    // Bit 0 ROM, 1 UART, 2 CLINT
  logic [2:0] d_hit;
  logic [2:0] slv_rdy;
  logic [2:0] own_i_q;  // Port served per slave
  logic [2:0] own_d_q;

  function automatic slave_e decode(input logic [31:0] addr);
    if (addr >= CLINT_BASE_ADDR && addr < CLINT_TOP_ADDR) begin
      return SLV_CLINT;
    end else if (addr >= UART_BASE_ADDR && addr < UART_TOP_ADDR) begin
      return SLV_UART;
    end else if (addr >= ROM_BASE_ADDR && addr < ROM_TOP_ADDR) begin
      return SLV_ROM;
    end
    return SLV_NONE;
  endfunction

  function automatic logic [31:0] base_of(input slave_e sel);
    case (sel)
      SLV_CLINT: return CLINT_BASE_ADDR;
      SLV_UART:  return UART_BASE_ADDR;
      default:   return ROM_BASE_ADDR;
    endcase
  endfunction

  function automatic logic [2:0] hit_of(input slave_e sel);
    return {sel == SLV_CLINT, sel == SLV_UART, sel == SLV_ROM};
  endfunction

  function automatic mem_req_t pick(input logic d_win, input logic i_win,
                                    input mem_req_t d_req, input mem_req_t i_req);
    mem_req_t req;
    req = '0;
    if (d_win) begin
      req = d_req;
    end else if (i_win) begin
      req = i_req;
    end
    return req;
  endfunction

  function automatic mem_rsp_t steer(input logic [2:0] own, input mem_rsp_t rom,
                                     input mem_rsp_t uart, input mem_rsp_t clint);
    mem_rsp_t rsp;
    rsp = '0;
    if (own[0] && rom.ready) begin
      rsp = rom;
    end else if (own[1] && uart.ready) begin
      rsp = uart;
    end else if (own[2] && clint.ready) begin
      rsp = clint;
    end
    return rsp;
  endfunction

  always_comb begin
    d_sel = dmem_req_i.valid ? decode(dmem_req_i.addr) : SLV_NONE;
    i_sel = imem_req_i.valid ? decode(imem_req_i.addr) : SLV_NONE;
    if (i_sel == d_sel) begin
      i_sel = SLV_NONE;  // Data port wins, fetch is dropped
    end

    d_fwd      = dmem_req_i;
    d_fwd.addr = dmem_req_i.addr - base_of(d_sel);
    i_fwd      = imem_req_i;
    i_fwd.addr = imem_req_i.addr - base_of(i_sel);

    d_hit = hit_of(d_sel);
    i_hit = hit_of(i_sel);
  end

  assign rom_req_o   = pick(d_hit[0], i_hit[0], d_fwd, i_fwd);
  assign uart_req_o  = pick(d_hit[1], i_hit[1], d_fwd, i_fwd);
  assign clint_req_o = pick(d_hit[2], i_hit[2], d_fwd, i_fwd);

  assign slv_rdy = {clint_rsp_i.ready, uart_rsp_i.ready, rom_rsp_i.ready};

  // Owner cleared on ready, set again by a new grant
  always_ff @(posedge clock) begin
    if (!reset) begin
      own_i_q <= '0;
      own_d_q <= '0;
    end else begin
      own_i_q <= (own_i_q & ~slv_rdy) | i_hit;
      own_d_q <= (own_d_q & ~slv_rdy) | d_hit;
    end
  end

  assign imem_rsp_o = steer(own_i_q, rom_rsp_i, uart_rsp_i, clint_rsp_i);
  assign dmem_rsp_o = steer(own_d_q, rom_rsp_i, uart_rsp_i, clint_rsp_i);

endmodule

`default_nettype wire

// File: design/soc_pkg.sv
`default_nettype none

package soc_pkg;

  // Address map, top is exclusive
  localparam logic [31:0] ROM_BASE_ADDR   = 32'h0000_0000;
  localparam logic [31:0] ROM_TOP_ADDR    = 32'h0000_0040;
  localparam logic [31:0] UART_BASE_ADDR  = 32'h0010_0000;
  localparam logic [31:0] UART_TOP_ADDR   = 32'h0010_0008;
  localparam logic [31:0] CLINT_BASE_ADDR = 32'h0200_0000;
  localparam logic [31:0] CLINT_TOP_ADDR  = 32'h0200_C000;

  localparam int ROM_WORDS = 16;

  // CLINT register offsets
  localparam logic [31:0] CLINT_MSIP      = 32'h0000_0000;
  localparam logic [31:0] CLINT_MTIMECMP  = 32'h0000_4000;
  localparam logic [31:0] CLINT_MTIMECMPH = 32'h0000_4004;
  localparam logic [31:0] CLINT_MTIME     = 32'h0000_BFF8;
  localparam logic [31:0] CLINT_MTIMEH    = 32'h0000_BFFC;

  // UART register offsets
  localparam logic [31:0] UART_DATA   = 32'h0000_0000;
  localparam logic [31:0] UART_STATUS = 32'h0000_0004;

  localparam int CLKS_PER_BIT = 8;
  localparam int UART_CNT_W   = $clog2(CLKS_PER_BIT);
  localparam logic [UART_CNT_W-1:0] UART_BIT_END = UART_CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [UART_CNT_W-1:0] UART_BIT_MID = UART_CNT_W'(CLKS_PER_BIT / 2 - 1);

  typedef struct packed {
    logic        valid;
    logic        instr;   // Fetch flag
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;   // Zero for a read
  } mem_req_t;

  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } mem_rsp_t;

  typedef enum logic [1:0] {
    SLV_NONE,
    SLV_ROM,
    SLV_UART,
    SLV_CLINT
  } slave_e;

  typedef enum logic [1:0] {
    UART_IDLE,
    UART_START,
    UART_BITS,
    UART_STOP
  } uart_state_e;

endpackage

`default_nettype wire
